//--- logic/cnv_pkg.sv
`default_nettype none

package cnv_pkg;

    // ========================================
    // Widths
    // ========================================

    // Activation and weight word, signed
    localparam int DATA_WIDTH = 8;
    // Full product of two words
    localparam int PROD_WIDTH = 2 * DATA_WIDTH;

    // Default geometry of one PE row
    localparam int BLOCK_DEPTH_DEF = 8;
    localparam int LEN_PSUM_DEF    = 6;

    // Three columns of lane products, default depth
    localparam int MAC_WIDTH  = PROD_WIDTH + $clog2(3 * BLOCK_DEPTH_DEF);
    // Headroom for repeated kernel-row accumulation
    localparam int PSUM_WIDTH = MAC_WIDTH + 2;

    // ========================================
    // Types
    // ========================================

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [PROD_WIDTH-1:0] prod_t;
    typedef logic signed [MAC_WIDTH-1:0]  mac_t;
    typedef logic signed [PSUM_WIDTH-1:0] psum_t;

    // Window sequencer states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        ACC
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/sparse_mac.sv
`timescale 1ns/1ps
`default_nettype none

module sparse_mac #(
    parameter int  BLOCK_DEPTH = cnv_pkg::BLOCK_DEPTH_DEF,
    localparam int LANE_W      = (BLOCK_DEPTH > 1) ? $clog2(BLOCK_DEPTH) : 1
) (
    input  wire                                      clk,
    input  wire                                      rst_n,
    input  wire                                      start,
    input  wire  [BLOCK_DEPTH-1:0]                   flg_act,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] act,
    input  wire  [BLOCK_DEPTH-1:0]                   flg_wei,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] wei,
    input  wire  cnv_pkg::mac_t                      chain_in,
    output cnv_pkg::mac_t                            mac_sum,
    output logic                                     fnh
);

    import cnv_pkg::*;

    // ========================================
    // Lane selection
    // ========================================

    // Lanes where both operands are nonzero
    logic [BLOCK_DEPTH-1:0] lane_mask;
    // Lanes still to be multiplied
    logic [BLOCK_DEPTH-1:0] pending;
    // Pending set with its lowest bit dropped
    logic [BLOCK_DEPTH-1:0] pending_nxt;
    logic [LANE_W-1:0]      lane_sel;
    data_t                  lane_act;
    data_t                  lane_wei;
    prod_t                  lane_prod;
    mac_t                   acc;

    assign lane_mask   = flg_act & flg_wei;
    assign pending_nxt = pending & (pending - 1'b1);

    // Priority pick, lowest pending lane wins
    always_comb begin
        lane_sel = '0;
        for (int i = BLOCK_DEPTH - 1; i >= 0; i--) begin
            if (pending[i]) begin
                lane_sel = LANE_W'(i);
            end
        end
    end

    // Operands of the selected lane
    assign lane_act  = act[lane_sel*DATA_WIDTH +: DATA_WIDTH];
    assign lane_wei  = wei[lane_sel*DATA_WIDTH +: DATA_WIDTH];
    assign lane_prod = lane_act * lane_wei;

    // ========================================
    // Sequencing
    // ========================================

    // One lane per cycle, fnh on the edge that takes the last lane
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pending <= '0;
            fnh     <= 1'b0;
        end else begin
            fnh <= 1'b0;
            if (start) begin
                pending <= lane_mask;
                // Empty window finishes at once
                fnh     <= ~|lane_mask;
            end else if (|pending) begin
                pending <= pending_nxt;
                if (pending_nxt == '0) begin
                    fnh <= 1'b1;
                end
            end
        end
    end

    // Accumulator, cleared at window start
    always_ff @(posedge clk) begin
        if (start) begin
            acc <= '0;
        end else if (|pending) begin
            acc <= acc + lane_prod;
        end
    end

    // Chained sum toward the next column
    assign mac_sum = acc + chain_in;

endmodule

`default_nettype wire

//--- logic/cnv_row.sv
`timescale 1ns/1ps
`default_nettype none

module cnv_row #(
    parameter int BLOCK_DEPTH = cnv_pkg::BLOCK_DEPTH_DEF
) (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        mac_start,
    input  wire                                        pls_acc,
    input  wire  [BLOCK_DEPTH-1:0]                     flg_act,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] act,
    input  wire  [BLOCK_DEPTH-1:0]                     flg_wei0,
    input  wire  [BLOCK_DEPTH-1:0]                     flg_wei1,
    input  wire  [BLOCK_DEPTH-1:0]                     flg_wei2,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] wei0,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] wei1,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] wei2,
    output logic                                       fnh0,
    output logic                                       fnh1,
    output logic                                       fnh2,
    input  wire  cnv_pkg::psum_t                       psum_in,
    output cnv_pkg::psum_t                             psum_out
);

    import cnv_pkg::*;

    localparam int VEC_W = DATA_WIDTH * BLOCK_DEPTH;

    // Per-column views of the weight ports
    logic [BLOCK_DEPTH-1:0] flg_wei_col [3];
    logic [VEC_W-1:0]       wei_col     [3];
    logic [2:0]             fnh_col;
    // chain[0] is the tied-off input of column 0
    mac_t                   chain       [4];

    assign flg_wei_col[0] = flg_wei0;
    assign flg_wei_col[1] = flg_wei1;
    assign flg_wei_col[2] = flg_wei2;
    assign wei_col[0]     = wei0;
    assign wei_col[1]     = wei1;
    assign wei_col[2]     = wei2;
    assign chain[0]       = '0;

    // ========================================
    // Kernel columns, chained 0 -> 1 -> 2
    // ========================================

    for (genvar g = 0; g < 3; g++) begin : g_col
        sparse_mac #(
            .BLOCK_DEPTH (BLOCK_DEPTH)
        ) mac_inst (
            .clk      (clk),
            .rst_n    (rst_n),
            .start    (mac_start),
            .flg_act  (flg_act),
            .act      (act),
            .flg_wei  (flg_wei_col[g]),
            .wei      (wei_col[g]),
            .chain_in (chain[g]),
            .mac_sum  (chain[g+1]),
            .fnh      (fnh_col[g])
        );
    end

    assign fnh0 = fnh_col[0];
    assign fnh1 = fnh_col[1];
    assign fnh2 = fnh_col[2];

    // Window sum onto the stored partial sum
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            psum_out <= '0;
        end else if (pls_acc) begin
            psum_out <= psum_in + chain[3];
        end
    end

endmodule

`default_nettype wire

//--- logic/psum_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module psum_buffer #(
    parameter int  LEN_PSUM = cnv_pkg::LEN_PSUM_DEF,
    localparam int ADDR_W   = (LEN_PSUM > 1) ? $clog2(LEN_PSUM) : 1
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    clr,
    input  wire  [ADDR_W-1:0]      rd_addr,
    output cnv_pkg::psum_t         rd_data,
    input  wire                    wr_en,
    input  wire  [ADDR_W-1:0]      wr_addr,
    input  wire  cnv_pkg::psum_t   wr_data
);

    import cnv_pkg::*;

    // One partial sum per output position of the row
    psum_t mem [LEN_PSUM];

    // ========================================
    // Write side
    // ========================================

    // Clear wins over a write in the same cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LEN_PSUM; i++) begin
                mem[i] <= '0;
            end
        end else if (clr) begin
            for (int i = 0; i < LEN_PSUM; i++) begin
                mem[i] <= '0;
            end
        end else if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // ========================================
    // Read side
    // ========================================

    // Combinational read at the current position
    assign rd_data = mem[rd_addr];

endmodule

`default_nettype wire

//--- logic/pe_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module pe_ctrl #(
    parameter int  LEN_PSUM = cnv_pkg::LEN_PSUM_DEF,
    localparam int ADDR_W   = (LEN_PSUM > 1) ? $clog2(LEN_PSUM) : 1
) (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               win_start,
    input  wire               buf_clr,
    input  wire               fnh0,
    input  wire               fnh1,
    input  wire               fnh2,
    output logic              mac_start,
    output logic              pls_acc,
    output logic              busy,
    output logic              row_done,
    output logic              psum_valid,
    output logic [ADDR_W-1:0] addr,
    output logic [ADDR_W-1:0] psum_wr_addr
);

    import cnv_pkg::*;

    localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(LEN_PSUM - 1);

    ctrl_state_t state;
    // Finish pulses seen so far this window
    logic [2:0]  fnh_seen;
    logic [2:0]  fnh_all;

    assign fnh_all = fnh_seen | {fnh2, fnh1, fnh0};
    assign busy    = (state != IDLE);
    // Accumulate for exactly the one ACC cycle
    assign pls_acc = (state == ACC);

    // ========================================
    // Window FSM
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= IDLE;
            fnh_seen   <= '0;
            mac_start  <= 1'b0;
            psum_valid <= 1'b0;
            row_done   <= 1'b0;
        end else begin
            mac_start  <= 1'b0;
            // Result leaves cnv_row one cycle after the accumulate
            psum_valid <= pls_acc;
            row_done   <= pls_acc && (addr == ADDR_LAST);
            case (state)
                IDLE: begin
                    // A start while busy never reaches here
                    if (win_start) begin
                        state     <= RUN;
                        mac_start <= 1'b1;
                        fnh_seen  <= '0;
                    end
                end
                RUN: begin
                    fnh_seen <= fnh_all;
                    if (&fnh_all) begin
                        state <= ACC;
                    end
                end
                ACC: begin
                    state <= IDLE;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // Position counter, wraps at the end of a row
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr         <= '0;
            psum_wr_addr <= '0;
        end else begin
            // Write-back target trails the read by one cycle
            if (pls_acc) begin
                psum_wr_addr <= addr;
            end
            if (buf_clr) begin
                addr <= '0;
            end else if (pls_acc) begin
                addr <= (addr == ADDR_LAST) ? '0 : addr + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/pe_row_top.sv
`timescale 1ns/1ps
`default_nettype none

module pe_row_top #(
    parameter int  BLOCK_DEPTH = cnv_pkg::BLOCK_DEPTH_DEF,
    parameter int  LEN_PSUM    = cnv_pkg::LEN_PSUM_DEF,
    localparam int ADDR_W      = (LEN_PSUM > 1) ? $clog2(LEN_PSUM) : 1
) (
    input  wire                                        clk,
    input  wire                                        rst_n,
    input  wire                                        win_start,
    input  wire                                        buf_clr,
    input  wire  [BLOCK_DEPTH-1:0]                     flg_act,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] act,
    input  wire  [BLOCK_DEPTH-1:0]                     flg_wei0,
    input  wire  [BLOCK_DEPTH-1:0]                     flg_wei1,
    input  wire  [BLOCK_DEPTH-1:0]                     flg_wei2,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] wei0,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] wei1,
    input  wire  [cnv_pkg::DATA_WIDTH*BLOCK_DEPTH-1:0] wei2,
    output logic                                       busy,
    output cnv_pkg::psum_t                             psum,
    output logic [ADDR_W-1:0]                          psum_addr,
    output logic                                       psum_valid,
    output logic                                       row_done
);

    import cnv_pkg::*;

    // ========================================
    // Internal nets
    // ========================================

    logic              mac_start;
    logic              pls_acc;
    logic              fnh0;
    logic              fnh1;
    logic              fnh2;
    // Read position of the current window
    logic [ADDR_W-1:0] addr;
    // Stored partial sum at addr
    psum_t             psum_rd;

    pe_ctrl #(
        .LEN_PSUM (LEN_PSUM)
    ) pe_ctrl_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .win_start    (win_start),
        .buf_clr      (buf_clr),
        .fnh0         (fnh0),
        .fnh1         (fnh1),
        .fnh2         (fnh2),
        .mac_start    (mac_start),
        .pls_acc      (pls_acc),
        .busy         (busy),
        .row_done     (row_done),
        .psum_valid   (psum_valid),
        .addr         (addr),
        .psum_wr_addr (psum_addr)
    );

    cnv_row #(
        .BLOCK_DEPTH (BLOCK_DEPTH)
    ) cnv_row_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .mac_start (mac_start),
        .pls_acc   (pls_acc),
        .flg_act   (flg_act),
        .act       (act),
        .flg_wei0  (flg_wei0),
        .flg_wei1  (flg_wei1),
        .flg_wei2  (flg_wei2),
        .wei0      (wei0),
        .wei1      (wei1),
        .wei2      (wei2),
        .fnh0      (fnh0),
        .fnh1      (fnh1),
        .fnh2      (fnh2),
        .psum_in   (psum_rd),
        .psum_out  (psum)
    );

    // Result written back in its psum_valid cycle
    psum_buffer #(
        .LEN_PSUM (LEN_PSUM)
    ) psum_buffer_inst (
        .clk     (clk),
        .rst_n   (rst_n),
        .clr     (buf_clr),
        .rd_addr (addr),
        .rd_data (psum_rd),
        .wr_en   (psum_valid),
        .wr_addr (psum_addr),
        .wr_data (psum)
    );

endmodule

`default_nettype wire

//--- verification/pe_row_checker.sv
`timescale 1ns/1ps
`default_nettype none

module pe_row_checker #(
    parameter int  BLOCK_DEPTH = cnv_pkg::BLOCK_DEPTH_DEF,
    parameter int  LEN_PSUM    = cnv_pkg::LEN_PSUM_DEF,
    localparam int ADDR_W      = (LEN_PSUM > 1) ? $clog2(LEN_PSUM) : 1,
    localparam int VEC_W       = cnv_pkg::DATA_WIDTH * BLOCK_DEPTH
) (
    input  wire                    clk,
    input  wire                    rst_n,
    input  wire                    win_start,
    input  wire                    buf_clr,
    input  wire  [BLOCK_DEPTH-1:0] flg_act,
    input  wire  [VEC_W-1:0]       act,
    input  wire  [BLOCK_DEPTH-1:0] flg_wei0,
    input  wire  [BLOCK_DEPTH-1:0] flg_wei1,
    input  wire  [BLOCK_DEPTH-1:0] flg_wei2,
    input  wire  [VEC_W-1:0]       wei0,
    input  wire  [VEC_W-1:0]       wei1,
    input  wire  [VEC_W-1:0]       wei2,
    input  wire                    busy,
    input  wire  cnv_pkg::psum_t   psum,
    input  wire  [ADDR_W-1:0]      psum_addr,
    input  wire                    psum_valid,
    input  wire                    row_done,
    output int                     err_cnt,
    output int                     result_cnt
);

    import cnv_pkg::*;

    // Model of the partial-sum row
    psum_t model_mem [LEN_PSUM];
    int    model_addr;
    // Expected result of the window in flight
    psum_t expected;
    logic  exp_done;
    logic  exp_busy;
    bit    pending;

    // ========================================
    // Reference
    // ========================================

    // Sum over three columns of products where both flags are set
    function automatic int window_sum(
        input logic [BLOCK_DEPTH-1:0]   fa,
        input logic [VEC_W-1:0]         a,
        input logic [3*BLOCK_DEPTH-1:0] fw,
        input logic [3*VEC_W-1:0]       w
    );
        int    sum;
        data_t a_lane;
        data_t w_lane;
        sum = 0;
        for (int c = 0; c < 3; c++) begin
            for (int l = 0; l < BLOCK_DEPTH; l++) begin
                if (fa[l] && fw[c*BLOCK_DEPTH + l]) begin
                    a_lane = a[l*DATA_WIDTH +: DATA_WIDTH];
                    w_lane = w[(c*BLOCK_DEPTH + l)*DATA_WIDTH +: DATA_WIDTH];
                    sum += int'(a_lane) * int'(w_lane);
                end
            end
        end
        return sum;
    endfunction

    task automatic report_mismatch(input string name, input longint exp_val,
                                   input longint got_val);
        $display("[FAIL] t=%0t %s expected %0d got %0d", $time, name, exp_val, got_val);
        err_cnt++;
    endtask

    // ========================================
    // Compare process
    // ========================================

    // Falling edge, all DUT signals settled
    always @(negedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < LEN_PSUM; i++) begin
                model_mem[i] = '0;
            end
            model_addr = 0;
            pending    = 1'b0;
            err_cnt    = 0;
            result_cnt = 0;
        end else begin
            // Busy spans a window from its start up to its result
            exp_busy = pending && !psum_valid;
            if (busy !== exp_busy) begin
                report_mismatch("busy", exp_busy, busy);
            end
            if (row_done && !psum_valid) begin
                $display("row_done high without a result at t=%0t", $time);
                err_cnt++;
            end
            if (psum_valid) begin
                if (!pending) begin
                    $display("Result at t=%0t with no window in flight", $time);
                    err_cnt++;
                end else begin
                    exp_done = (model_addr == LEN_PSUM - 1);
                    if (psum !== expected) begin
                        report_mismatch("psum", expected, psum);
                    end
                    if (int'(psum_addr) != model_addr) begin
                        report_mismatch("psum_addr", model_addr, psum_addr);
                    end
                    if (row_done !== exp_done) begin
                        report_mismatch("row_done", exp_done, row_done);
                    end
                    // Write-back and position step of the model
                    model_mem[model_addr] = expected;
                    model_addr = (model_addr == LEN_PSUM - 1) ? 0 : model_addr + 1;
                    pending = 1'b0;
                    result_cnt++;
                end
            end
            if (buf_clr) begin
                for (int i = 0; i < LEN_PSUM; i++) begin
                    model_mem[i] = '0;
                end
                model_addr = 0;
            end
            // A start during a window in flight is ignored
            if (win_start && !pending) begin
                pending  = 1'b1;
                expected = psum_t'(window_sum(flg_act, act, {flg_wei2, flg_wei1, flg_wei0},
                                              {wei2, wei1, wei0}))
                           + model_mem[model_addr];
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/tb_pe_row.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pe_row;

    import cnv_pkg::*;

    localparam int BLOCK_DEPTH = BLOCK_DEPTH_DEF;
    localparam int LEN_PSUM    = LEN_PSUM_DEF;
    localparam int ADDR_W      = (LEN_PSUM > 1) ? $clog2(LEN_PSUM) : 1;
    localparam int VEC_W       = DATA_WIDTH * BLOCK_DEPTH;
    // Cycles allowed for any single wait
    localparam int WAIT_LIMIT  = 200;

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   win_start;
    logic                   buf_clr;
    logic [BLOCK_DEPTH-1:0] flg_act;
    logic [VEC_W-1:0]       act;
    logic [BLOCK_DEPTH-1:0] flg_wei0;
    logic [BLOCK_DEPTH-1:0] flg_wei1;
    logic [BLOCK_DEPTH-1:0] flg_wei2;
    logic [VEC_W-1:0]       wei0;
    logic [VEC_W-1:0]       wei1;
    logic [VEC_W-1:0]       wei2;
    logic                   busy;
    psum_t                  psum;
    logic [ADDR_W-1:0]      psum_addr;
    logic                   psum_valid;
    logic                   row_done;

    int          err_cnt;
    int          result_cnt;
    int          timeout_cnt = 0;
    int          window_cnt  = 0;
    bit          aborted     = 1'b0;
    logic [31:0] lfsr        = 32'd99685;

    // 100 ns period
    always #50 clk = ~clk;

    pe_row_top #(
        .BLOCK_DEPTH (BLOCK_DEPTH),
        .LEN_PSUM    (LEN_PSUM)
    ) pe_row_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_start  (win_start),
        .buf_clr    (buf_clr),
        .flg_act    (flg_act),
        .act        (act),
        .flg_wei0   (flg_wei0),
        .flg_wei1   (flg_wei1),
        .flg_wei2   (flg_wei2),
        .wei0       (wei0),
        .wei1       (wei1),
        .wei2       (wei2),
        .busy       (busy),
        .psum       (psum),
        .psum_addr  (psum_addr),
        .psum_valid (psum_valid),
        .row_done   (row_done)
    );

    pe_row_checker #(
        .BLOCK_DEPTH (BLOCK_DEPTH),
        .LEN_PSUM    (LEN_PSUM)
    ) pe_row_checker_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .win_start  (win_start),
        .buf_clr    (buf_clr),
        .flg_act    (flg_act),
        .act        (act),
        .flg_wei0   (flg_wei0),
        .flg_wei1   (flg_wei1),
        .flg_wei2   (flg_wei2),
        .wei0       (wei0),
        .wei1       (wei1),
        .wei2       (wei2),
        .busy       (busy),
        .psum       (psum),
        .psum_addr  (psum_addr),
        .psum_valid (psum_valid),
        .row_done   (row_done),
        .err_cnt    (err_cnt),
        .result_cnt (result_cnt)
    );

    // ========================================
    // Random source
    // ========================================

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [VEC_W-1:0] rand_vec();
        logic [VEC_W-1:0] v;
        logic [31:0]      r;
        for (int l = 0; l < BLOCK_DEPTH; l++) begin
            r = rand_bits(DATA_WIDTH);
            v[l*DATA_WIDTH +: DATA_WIDTH] = r[DATA_WIDTH-1:0];
        end
        return v;
    endfunction

    // Same word in every lane
    function automatic logic [VEC_W-1:0] fill_vec(input logic [DATA_WIDTH-1:0] val);
        logic [VEC_W-1:0] v;
        for (int l = 0; l < BLOCK_DEPTH; l++) begin
            v[l*DATA_WIDTH +: DATA_WIDTH] = val;
        end
        return v;
    endfunction

    // ========================================
    // Window driving
    // ========================================

    task automatic drive_window(
        input logic [BLOCK_DEPTH-1:0] fa,
        input logic [VEC_W-1:0]       a,
        input logic [BLOCK_DEPTH-1:0] fw0,
        input logic [BLOCK_DEPTH-1:0] fw1,
        input logic [BLOCK_DEPTH-1:0] fw2,
        input logic [VEC_W-1:0]       w0,
        input logic [VEC_W-1:0]       w1,
        input logic [VEC_W-1:0]       w2,
        input bit                     start_twice
    );
        int waited;
        if (aborted) begin
            return;
        end
        @(posedge clk);
        flg_act   <= fa;
        act       <= a;
        flg_wei0  <= fw0;
        flg_wei1  <= fw1;
        flg_wei2  <= fw2;
        wei0      <= w0;
        wei1      <= w1;
        wei2      <= w2;
        win_start <= 1'b1;
        @(posedge clk);
        win_start <= 1'b0;
        window_cnt++;
        if (start_twice) begin
            waited = 0;
            @(negedge clk);
            while (!busy && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (!busy) begin
                $display("Timeout: busy never rose after win_start");
                timeout_cnt++;
                aborted = 1'b1;
                return;
            end
            // Second pulse lands while the MACs still run
            @(posedge clk);
            win_start <= 1'b1;
            @(posedge clk);
            win_start <= 1'b0;
        end
        waited = 0;
        @(negedge clk);
        while (!psum_valid && waited < WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!psum_valid) begin
            $display("Timeout: no psum_valid within %0d cycles of win_start", WAIT_LIMIT);
            timeout_cnt++;
            aborted = 1'b1;
        end
    endtask

    task automatic random_window();
        logic [31:0]            r;
        logic [BLOCK_DEPTH-1:0] fa;
        logic [BLOCK_DEPTH-1:0] f0;
        logic [BLOCK_DEPTH-1:0] f1;
        logic [BLOCK_DEPTH-1:0] f2;
        logic [VEC_W-1:0]       a;
        logic [VEC_W-1:0]       w0;
        logic [VEC_W-1:0]       w1;
        logic [VEC_W-1:0]       w2;
        r  = rand_bits(BLOCK_DEPTH);
        fa = r[BLOCK_DEPTH-1:0];
        r  = rand_bits(BLOCK_DEPTH);
        f0 = r[BLOCK_DEPTH-1:0];
        r  = rand_bits(BLOCK_DEPTH);
        f1 = r[BLOCK_DEPTH-1:0];
        r  = rand_bits(BLOCK_DEPTH);
        f2 = r[BLOCK_DEPTH-1:0];
        a  = rand_vec();
        w0 = rand_vec();
        w1 = rand_vec();
        w2 = rand_vec();
        drive_window(fa, a, f0, f1, f2, w0, w1, w2, 1'b0);
    endtask

    task automatic clear_buffer();
        if (aborted) begin
            return;
        end
        @(posedge clk);
        buf_clr <= 1'b1;
        @(posedge clk);
        buf_clr <= 1'b0;
    endtask

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        rst_n     = 1'b0;
        win_start = 1'b0;
        buf_clr   = 1'b0;
        flg_act   = '0;
        act       = '0;
        flg_wei0  = '0;
        flg_wei1  = '0;
        flg_wei2  = '0;
        wei0      = '0;
        wei1      = '0;
        wei2      = '0;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        // Quiet cycles before the first window
        repeat (3) @(posedge clk);

        // Two full rows and part of a third, no clear
        for (int i = 0; i < 2 * LEN_PSUM + 3; i++) begin
            random_window();
        end

        // Fresh row after clear
        clear_buffer();
        for (int i = 0; i < LEN_PSUM; i++) begin
            random_window();
        end

        // Corner windows
        drive_window('0, rand_vec(), '0, '0, '0, rand_vec(), rand_vec(), rand_vec(), 1'b0);
        drive_window('1, fill_vec(8'h80), '1, '1, '1,
                     fill_vec(8'h80), fill_vec(8'h80), fill_vec(8'h80), 1'b0);
        drive_window('1, fill_vec(8'h7f), '1, '1, '1,
                     fill_vec(8'h80), fill_vec(8'h80), fill_vec(8'h80), 1'b0);
        drive_window('1, fill_vec(8'h7f), '1, '1, '1,
                     fill_vec(8'h7f), fill_vec(8'h81), fill_vec(8'h7f), 1'b1);

        // Let the checker see the last result
        repeat (2) @(posedge clk);
        if (!aborted && result_cnt != window_cnt) begin
            $display("Number of results differs from the number of windows driven");
        end
        $display("Summary: %0d mismatches, %0d timeouts, %0d of %0d results checked",
                 err_cnt, timeout_cnt, result_cnt, window_cnt);
        if (err_cnt == 0 && timeout_cnt == 0 && result_cnt == window_cnt) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
logic/cnv_pkg.sv
logic/sparse_mac.sv
logic/cnv_row.sv
logic/psum_buffer.sv
logic/pe_ctrl.sv
logic/pe_row_top.sv
verification/pe_row_checker.sv
verification/tb_pe_row.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tb_pe_row
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = Test passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass or fail comes from the log, not from the exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
